//--- verif/mem_stim.txt
# W port addr line | G addr0 addr1 addr2 addr3 rd raddr | R addr line
# Lines are 128-bit hex, word 0 rightmost. R with * expects the model's line.
# G data comes from the LFSR; rd=1 adds a read in the cycle the writes are raised.
# Consecutive R lines are issued on consecutive cycles.
G 00000100 00000104 00000108 0000010C 0 00000000
R 00000100 *
R 0000010C *
G 00000108 00000200 00000210 00000220 1 00000100
R 00000100 *
R 00000200 *
W 0 00000000 a3a3a3a3a2a2a2a2a1a1a1a1a0a0a0a0
R 00000000 a3a3a3a3a2a2a2a2a1a1a1a1a0a0a0a0
W 1 00000010 b3b3b3b3b2b2b2b2b1b1b1b1b0b0b0b0
W 2 00000014 c3c3c3c3c2c2c2c2c1c1c1c1c0c0c0c0
R 00000008 c0c0c0c0b0b0b0b0a3a3a3a3a2a2a2a2
R 00000010 c2c2c2c2c1c1c1c1c0c0c0c0b0b0b0b0
W 3 00000028 d3d3d3d3d2d2d2d2d1d1d1d1d0d0d0d0
W 0 0000003C e3e3e3e3e2e2e2e2e1e1e1e1e0e0e0e0
R 00000028 *
R 0000003C *
W 2 00000FFC f3f3f3f3f2f2f2f2f1f1f1f1f0f0f0f0
R 00000FFC f3f3f3f3f2f2f2f2f1f1f1f1f0f0f0f0
R 00000000 a3a3a3a3f3f3f3f3f2f2f2f2f1f1f1f1

//--- sources.f
rtl/mem_pkg.sv
rtl/mem_arbiter.sv
rtl/bank_mapper.sv
rtl/ram_bank.sv
rtl/read_aligner.sv
rtl/mem_main.sv
verif/mem_main_assert.sv
verif/tb_mem_main.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --top-module tb_mem_main \
  -f sources.f -Mdir obj_dir -o tb_mem_main

./obj_dir/tb_mem_main +verilator+error+limit+100 2>&1 | tee "$LOG"

if grep -q "TB FAILED" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi

echo "Simulation finished without failures"

//--- verif/tb_mem_main.sv
`timescale 1ns/1ps

module tb_mem_main;

  import mem_pkg::*;

  localparam int NUM_RT      = 4;
  localparam int BANK_ADDR_W = 8;
  localparam int IDX_W       = BANK_ADDR_W + 2;  // Word index over all banks.

  logic                 clk;
  logic                 rst;
  rt_req_t [NUM_RT-1:0] rt_req;
  logic                 re_mc;
  byte_addr_t           addr_mc;
  logic [NUM_RT-1:0]    rdy_rt;
  line_t                data_mc_out;
  logic                 rdy_mc;

  word_t             model [2**IDX_W];
  logic [NUM_RT-1:0] pend;
  logic [NUM_RT-1:0] drop;
  int                rr_ptr;
  line_t             exp_q[$];
  int                due_q[$];
  byte_addr_t        raddr_q[$];
  string             cmds[$];
  logic [31:0]       lfsr;
  int                errors;
  int                cycle_cnt = 0;
  int                limit;
  bit                done;

  mem_main i_dut (
    .clk         (clk),
    .rst         (rst),
    .rt_req      (rt_req),
    .re_mc       (re_mc),
    .addr_mc     (addr_mc),
    .rdy_rt      (rdy_rt),
    .data_mc_out (data_mc_out),
    .rdy_mc      (rdy_mc)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_line(output line_t l);
    for (int i = 0; i < $bits(line_t); i++) begin
      lfsr = lfsr_step(lfsr);
      l[i] = lfsr[0];
    end
  endtask

  function automatic line_t model_line(input byte_addr_t a);
    line_t            l;
    logic [IDX_W-1:0] base;
    base = a[IDX_W+1:2];
    for (int w = 0; w < LINE_WORDS; w++) begin
      l[w*32 +: 32] = model[base + IDX_W'(w)];  // Wraps at the top of the banks.
    end
    return l;
  endfunction

  task automatic model_store(input byte_addr_t a, input line_t l);
    logic [IDX_W-1:0] base;
    base = a[IDX_W+1:2];
    for (int w = 0; w < LINE_WORDS; w++) begin
      model[base + IDX_W'(w)] = l[w*32 +: 32];
    end
  endtask

  ////////////////////////////////////////
  // Per-cycle checks
  ////////////////////////////////////////

  task automatic check_writes();
    int                exp_port;
    logic [NUM_RT-1:0] exp_vec;
    exp_port = -1;
    exp_vec = '0;
    // Ports acknowledged last cycle drop their request now.
    for (int j = 0; j < NUM_RT; j++) begin
      if (drop[j]) begin
        rt_req[j].we = 1'b0;
      end
    end
    drop = '0;
    if (rdy_rt !== '0) begin
      // Next winner is the first pending port from the pointer up.
      for (int k = 0; k < NUM_RT; k++) begin
        if (exp_port < 0 && pend[(rr_ptr + k) % NUM_RT]) begin
          exp_port = (rr_ptr + k) % NUM_RT;
        end
      end
      if (exp_port >= 0) begin
        exp_vec[exp_port] = 1'b1;
      end
      if (rdy_rt !== exp_vec) begin
        $display("CHECK FAILED rdy_rt: got %h expected %h", rdy_rt, exp_vec);
        errors++;
      end
      for (int j = 0; j < NUM_RT; j++) begin
        if (rdy_rt[j] === 1'b1 && pend[j]) begin
          model_store(rt_req[j].addr, rt_req[j].data);
          pend[j] = 1'b0;
          drop[j] = 1'b1;  // Request stays up through the ack cycle.
          rr_ptr = (j + 1) % NUM_RT;
        end
      end
    end
  endtask

  task automatic check_read();
    if (due_q.size() > 0 && due_q[0] == cycle_cnt) begin
      if (rdy_mc !== 1'b1) begin
        $display("Missing rdy_mc pulse two cycles after the read of %h", raddr_q[0]);
        errors++;
      end else if (data_mc_out !== exp_q[0]) begin
        $display("CHECK FAILED data_mc_out: got %h expected %h (addr %h)",
                 data_mc_out, exp_q[0], raddr_q[0]);
        errors++;
      end
      due_q.delete(0);
      exp_q.delete(0);
      raddr_q.delete(0);
    end else if (rdy_mc !== 1'b0) begin
      $display("CHECK FAILED rdy_mc: got %h expected 0", rdy_mc);
      errors++;
    end
  endtask

  task automatic step_cycle();
    @(negedge clk);
    check_writes();
    check_read();
    re_mc = 1'b0;  // Read strobe lasts one cycle.
  endtask

  task automatic raise_write(input int port, input byte_addr_t a, input line_t d);
    rt_req[port].we = 1'b1;
    rt_req[port].addr = a;
    rt_req[port].data = d;
    pend[port] = 1'b1;
  endtask

  task automatic issue_read(input byte_addr_t a, input line_t exp);
    re_mc = 1'b1;
    addr_mc = a;
    exp_q.push_back(exp);
    due_q.push_back(cycle_cnt + 2);
    raddr_q.push_back(a);
  endtask

  task automatic drain_requests();
    while (pend != '0 || drop != '0 || due_q.size() > 0) begin
      step_cycle();
    end
  endtask

  initial begin
    wait (limit > 0);
    while (!done && cycle_cnt < limit) begin
      @(negedge clk);
    end
    if (!done) begin
      $display("Timeout after %0d cycles with requests still open", limit);
      $display("TB FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    string      line;
    string      args;
    byte        cmd;
    int         fd;
    int         n;
    int         port;
    int         rd;
    byte_addr_t a [NUM_RT];
    byte_addr_t ra;
    line_t      d;
    rst = 1'b1;
    re_mc = 1'b0;
    addr_mc = '0;
    rt_req = '0;
    pend = '0;
    drop = '0;
    rr_ptr = 0;
    errors = 0;
    done = 1'b0;
    limit = 0;
    lfsr = 32'he8d6_6f2c;
    fd = $fopen("verif/mem_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file verif/mem_stim.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#") begin
          cmds.push_back(line);
        end
      end
      $fclose(fd);
    end
    limit = 20 * cmds.size() + 100;

    repeat (16) begin
      @(negedge clk);
      if (rdy_rt !== '0 || rdy_mc !== 1'b0) begin
        $display("CHECK FAILED rdy_rt/rdy_mc in reset: got %h/%h expected 0/0",
                 rdy_rt, rdy_mc);
        errors++;
      end
    end
    rst = 1'b0;
    repeat (4) step_cycle();  // Idle, both readies must stay low.

    foreach (cmds[i]) begin
      cmd = cmds[i].getc(0);
      args = cmds[i].substr(1, cmds[i].len() - 1);
      case (cmd)
        "W": begin
          n = $sscanf(args, "%d %h %h", port, ra, d);
          raise_write(port, ra, d);
          drain_requests();
        end
        "G": begin
          n = $sscanf(args, "%h %h %h %h %d %h", a[0], a[1], a[2], a[3], rd, ra);
          for (int p = 0; p < NUM_RT; p++) begin
            random_line(d);
            raise_write(p, a[p], d);
          end
          if (rd != 0) begin
            issue_read(ra, model_line(ra));  // Contents before the group.
          end
          drain_requests();
        end
        "R": begin
          n = $sscanf(args, "%h %h", ra, d);
          if (n < 2) begin
            d = model_line(ra);
          end
          issue_read(ra, d);
          step_cycle();
          // A run of R lines goes out on consecutive cycles.
          if (i + 1 >= cmds.size() || cmds[i + 1].getc(0) != "R") begin
            drain_requests();
          end
        end
        default: begin
          $display("Unknown command in the stimulus file: %s", cmds[i]);
          errors++;
        end
      endcase
    end

    drain_requests();
    done = 1'b1;
    errors += i_dut.i_assert.fail_cnt;
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- verif/mem_main_assert.sv
`timescale 1ns/1ps

module mem_main_assert #(
  parameter int NUM_RT = 4
) (
  input logic                          clk,
  input logic                          rst,
  input mem_pkg::rt_req_t [NUM_RT-1:0] rt_req,
  input logic                          re_mc,
  input logic [NUM_RT-1:0]             rdy_rt,
  input logic                          rdy_mc
);

  import mem_pkg::*;

  logic [NUM_RT-1:0] we_vec;
  int                fail_onehot = 0;
  int                fail_ack = 0;
  int                fail_rd = 0;
  int                fail_rst = 0;
  int                fail_cnt;

  always_comb begin
    for (int k = 0; k < NUM_RT; k++) begin
      we_vec[k] = rt_req[k].we;
    end
  end

  assign fail_cnt = fail_onehot + fail_ack + fail_rd + fail_rst;

  ////////////////////////////////////////
  // Handshake properties
  ////////////////////////////////////////

  rdy_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(rdy_rt))
    else begin
      $error("rdy_rt has more than one bit set");
      fail_onehot++;
    end

  // Ack only for a port that was requesting.
  rdy_after_we: assert property (@(posedge clk) disable iff (rst)
    (rdy_rt & ~$past(we_vec)) == '0)
    else begin
      $error("rdy_rt pulse on a port without a request");
      fail_ack++;
    end

  rd_latency: assert property (@(posedge clk) disable iff (rst) rdy_mc == $past(re_mc, 2))
    else begin
      $error("rdy_mc does not follow re_mc by two cycles");
      fail_rd++;
    end

  quiet_after_rst: assert property (@(posedge clk) $fell(rst) |-> (rdy_rt == '0 && !rdy_mc))
    else begin
      $error("ready output high right after reset");
      fail_rst++;
    end

endmodule

bind mem_main mem_main_assert #(
  .NUM_RT (NUM_RT)
) i_assert (
  .clk    (clk),
  .rst    (rst),
  .rt_req (rt_req),
  .re_mc  (re_mc),
  .rdy_rt (rdy_rt),
  .rdy_mc (rdy_mc)
);

//--- rtl/mem_main.sv
`timescale 1ns/1ps

module mem_main #(
  parameter int NUM_RT      = 4,
  parameter int BANK_ADDR_W = 8
) (
  input  logic                            clk,
  input  logic                            rst,
  input  mem_pkg::rt_req_t [NUM_RT-1:0]   rt_req,
  input  logic                            re_mc,
  input  mem_pkg::byte_addr_t             addr_mc,
  output logic [NUM_RT-1:0]               rdy_rt,
  output mem_pkg::line_t                  data_mc_out,
  output logic                            rdy_mc
);

  import mem_pkg::*;

  mem_req_t                                 grant;
  logic [LINE_WORDS-1:0]                    bank_we;
  logic [LINE_WORDS-1:0][BANK_ADDR_W-1:0]   bank_addr;
  word_t [LINE_WORDS-1:0]                   bank_din;
  word_t [LINE_WORDS-1:0]                   bank_dout;

  ////////////////////////////////////////
  // Request selection
  ////////////////////////////////////////

  mem_arbiter #(
    .NUM_RT (NUM_RT)
  ) i_arbiter (
    .clk     (clk),
    .rst     (rst),
    .rt_req  (rt_req),
    .re_mc   (re_mc),
    .addr_mc (addr_mc),
    .grant   (grant),
    .rdy_rt  (rdy_rt)
  );

  bank_mapper #(
    .BANK_ADDR_W (BANK_ADDR_W)
  ) i_mapper (
    .grant     (grant),
    .bank_we   (bank_we),
    .bank_addr (bank_addr),
    .bank_din  (bank_din)
  );

  ////////////////////////////////////////
  // Word-interleaved banks
  ////////////////////////////////////////

  for (genvar b = 0; b < LINE_WORDS; b++) begin : g_bank
    ram_bank #(
      .BANK_ADDR_W (BANK_ADDR_W)
    ) i_bank (
      .clk  (clk),
      .we   (bank_we[b]),
      .addr (bank_addr[b]),
      .din  (bank_din[b]),
      .dout (bank_dout[b])
    );
  end

  read_aligner i_aligner (
    .clk         (clk),
    .rst         (rst),
    .grant       (grant),
    .bank_dout   (bank_dout),
    .data_mc_out (data_mc_out),
    .rdy_mc      (rdy_mc)
  );

endmodule

//--- rtl/read_aligner.sv
`timescale 1ns/1ps

module read_aligner (
  input  logic                                         clk,
  input  logic                                         rst,
  input  mem_pkg::mem_req_t                            grant,
  input  mem_pkg::word_t [mem_pkg::LINE_WORDS-1:0]     bank_dout,
  output mem_pkg::line_t                               data_mc_out,
  output logic                                         rdy_mc
);

  import mem_pkg::*;

  logic                   rd_q;
  word_off_t              off_q;
  word_t [LINE_WORDS-1:0] line_words;

  ////////////////////////////////////////
  // Undo the bank rotation
  ////////////////////////////////////////

  for (genvar w = 0; w < LINE_WORDS; w++) begin : g_word
    word_off_t b_sel;

    assign b_sel = word_off_t'(w) + off_q;
    assign line_words[w] = bank_dout[b_sel];
  end

  // Valid pipeline, two reads may be in flight.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_q <= 1'b0;
      rdy_mc <= 1'b0;
    end else begin
      rd_q <= grant.rd;
      rdy_mc <= rd_q;
    end
  end

  always_ff @(posedge clk) begin
    off_q <= grant.addr[3:2];  // Aligned with bank dout.
    if (rd_q) begin
      data_mc_out <= line_words;
    end
  end

endmodule

//--- rtl/ram_bank.sv
`timescale 1ns/1ps

module ram_bank #(
  parameter int BANK_ADDR_W = 8
) (
  input  logic                   clk,
  input  logic                   we,
  input  logic [BANK_ADDR_W-1:0] addr,
  input  mem_pkg::word_t         din,
  output mem_pkg::word_t         dout
);

  import mem_pkg::*;

  word_t mem [2**BANK_ADDR_W];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= din;
    end
    dout <= mem[addr];  // Registered read, old data on a write.
  end

endmodule

//--- rtl/bank_mapper.sv
`timescale 1ns/1ps

module bank_mapper #(
  parameter int BANK_ADDR_W = 8
) (
  input  mem_pkg::mem_req_t                                      grant,
  output logic [mem_pkg::LINE_WORDS-1:0]                         bank_we,
  output logic [mem_pkg::LINE_WORDS-1:0][BANK_ADDR_W-1:0]        bank_addr,
  output mem_pkg::word_t [mem_pkg::LINE_WORDS-1:0]               bank_din
);

  import mem_pkg::*;

  word_off_t                        off;
  logic [BANK_ADDR_W-1:0]           line_idx;
  word_t [LINE_WORDS-1:0]           line_words;

  assign off = grant.addr[3:2];
  assign line_idx = grant.addr[BANK_ADDR_W+3:4];  // Upper bits wrap.
  assign line_words = grant.data;

  ////////////////////////////////////////
  // Per-bank rotation
  ////////////////////////////////////////

  for (genvar b = 0; b < LINE_WORDS; b++) begin : g_bank
    word_off_t w_sel;

    // Line word (b - off) mod 4 lands in bank b.
    assign w_sel = word_off_t'(b) - off;
    assign bank_din[b] = line_words[w_sel];

    // Banks below the offset hold the tail of the line, one row up.
    assign bank_addr[b] = (b < off) ? BANK_ADDR_W'(line_idx + 1'b1) : line_idx;

    assign bank_we[b] = grant.wr;
  end

endmodule

//--- rtl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter #(
  parameter int NUM_RT = 4
) (
  input  logic                            clk,
  input  logic                            rst,
  input  mem_pkg::rt_req_t [NUM_RT-1:0]   rt_req,
  input  logic                            re_mc,
  input  mem_pkg::byte_addr_t             addr_mc,
  output mem_pkg::mem_req_t               grant,
  output logic [NUM_RT-1:0]               rdy_rt
);

  import mem_pkg::*;

  localparam int PTR_W = (NUM_RT > 1) ? $clog2(NUM_RT) : 1;

  logic [PTR_W-1:0] rr_ptr;
  logic [PTR_W-1:0] win_idx;
  logic [PTR_W-1:0] next_ptr;
  logic             win_valid;

  ////////////////////////////////////////
  // Round-robin search
  ////////////////////////////////////////

  always_comb begin
    int cand;
    cand = 0;
    win_valid = 1'b0;
    win_idx = '0;
    for (int k = 0; k < NUM_RT; k++) begin
      cand = (int'(rr_ptr) + k) % NUM_RT;
      // Port already acknowledged this cycle is dropping its request.
      if (!win_valid && rt_req[cand].we && !rdy_rt[cand]) begin
        win_valid = 1'b1;
        win_idx = PTR_W'(cand);
      end
    end
  end

  assign next_ptr = (win_idx == PTR_W'(NUM_RT - 1)) ? '0 : win_idx + 1'b1;

  // Read strobe has priority over any write.
  always_comb begin
    grant = '0;
    if (re_mc) begin
      grant.rd = 1'b1;
      grant.addr = addr_mc;
    end else if (win_valid) begin
      grant.wr = 1'b1;
      grant.addr = rt_req[win_idx].addr;
      grant.data = rt_req[win_idx].data;
    end
  end

  ////////////////////////////////////////
  // Pointer and ready pulses
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      rr_ptr <= '0;
      rdy_rt <= '0;
    end else begin
      rdy_rt <= '0;
      if (grant.wr) begin
        rdy_rt <= NUM_RT'(1) << win_idx;  // One-hot ack.
        rr_ptr <= next_ptr;
      end
    end
  end

endmodule

//--- rtl/mem_pkg.sv
package mem_pkg;

  localparam int LINE_WORDS = 4;  // Words per line, also the bank count.

  typedef logic [31:0] byte_addr_t;
  typedef logic [31:0] word_t;
  typedef logic [LINE_WORDS*32-1:0] line_t;

  // Word position inside a line, taken from byte address bits 3:2.
  typedef logic [1:0] word_off_t;

  ////////////////////////////////////////
  // Request structs
  ////////////////////////////////////////

  typedef struct packed {
    logic       we;
    byte_addr_t addr;
    line_t      data;
  } rt_req_t;

  typedef struct packed {
    logic       rd;    // Controller read.
    logic       wr;    // Ray-tracer write.
    byte_addr_t addr;
    line_t      data;
  } mem_req_t;

endpackage
